/* Bender.yml */
package:
  name: bt_bridge

sources:
  - source/bt_bridge_pkg.sv
  - source/sample_intake.sv
  - source/stream_fifo.sv
  - source/stream_selector.sv
  - source/char_sequencer.sv
  - source/uart_tx.sv
  - source/bt_bridge_top.sv
  - target: test
    files:
      - test/bt_bridge_asserts.sv
      - test/bt_bridge_tb.sv

/* flist.f */
source/bt_bridge_pkg.sv
source/sample_intake.sv
source/stream_fifo.sv
source/stream_selector.sv
source/char_sequencer.sv
source/uart_tx.sv
source/bt_bridge_top.sv
test/bt_bridge_asserts.sv
test/bt_bridge_tb.sv

/* source/bt_bridge_pkg.sv */
package bt_bridge_pkg;

	// One UART character, also one sensor sample
	localparam int byte_w = 8;

	// Lane index, enough for up to 8 lanes
	localparam int lane_id_w = 3;

	// One FIFO entry; the identifier goes out on the line first
	typedef struct packed {
		logic [byte_w-1:0] lane_id;
		logic [byte_w-1:0] sample;
	} lane_word_t;

	// Word sequencer, one word in flight at a time
	typedef enum logic [2:0] {
		seq_idle,
		seq_release,
		seq_load,
		seq_send_id,
		seq_gap_id,
		seq_send_sample,
		seq_gap_sample
	} seq_state_e;

	// 8N1 serializer
	typedef enum logic [1:0] {
		uart_idle,
		uart_start_bit,
		uart_data_bits,
		uart_stop_bit
	} uart_state_e;

endpackage

/* source/bt_bridge_top.sv */
`timescale 1ns/1ps

module bt_bridge_top #(
	parameter int num_lanes = 8,
	parameter int fifo_depth = 4,
	parameter int cycles_per_bit = 4,
	parameter int char_gap = 3
) (
	input  logic                                           clock,
	input  logic                                           reset,
	input  logic [num_lanes-1:0]                           sample_valid,
	input  logic [num_lanes-1:0][bt_bridge_pkg::byte_w-1:0] sample_data,
	input  logic [num_lanes-1:0]                           lane_enable,
	input  logic                                           send_enable,
	output logic                                           txd,
	output logic [num_lanes-1:0]                           overflow,
	output logic                                           busy
);
	import bt_bridge_pkg::*;

	// Intake to lanes
	logic [num_lanes-1:0] push;
	lane_word_t [num_lanes-1:0] push_word;
	logic [num_lanes-1:0] lane_full;

	// Lanes to selector
	lane_word_t [num_lanes-1:0] lane_head;
	logic [num_lanes-1:0] lane_empty;
	logic [num_lanes-1:0] lane_pop;

	// Selector, sequencer and serializer
	logic have_word;
	lane_word_t sel_word;
	logic pop_req;
	logic tx_start;
	logic [byte_w-1:0] tx_char;
	logic tx_done;

	sample_intake #(
		.num_lanes(num_lanes)
	) u_intake (
		.clock(clock),
		.reset(reset),
		.sample_valid(sample_valid),
		.sample_data(sample_data),
		.lane_full(lane_full),
		.push(push),
		.push_word(push_word),
		.overflow(overflow)
	);

	for (genvar i = 0; i < num_lanes; i++)
	begin : g_lane
		stream_fifo #(
			.fifo_depth(fifo_depth)
		) u_fifo (
			.clock(clock),
			.reset(reset),
			.push(push[i]),
			.push_word(push_word[i]),
			.pop(lane_pop[i]),
			.head_word(lane_head[i]),
			.empty(lane_empty[i]),
			.full(lane_full[i])
		);
	end

	stream_selector #(
		.num_lanes(num_lanes)
	) u_selector (
		.clock(clock),
		.reset(reset),
		.lane_enable(lane_enable),
		.lane_empty(lane_empty),
		.lane_head(lane_head),
		.pop_req(pop_req),
		.have_word(have_word),
		.word(sel_word),
		.lane_pop(lane_pop)
	);

	char_sequencer #(
		.char_gap(char_gap)
	) u_sequencer (
		.clock(clock),
		.reset(reset),
		.send_enable(send_enable),
		.have_word(have_word),
		.word(sel_word),
		.pop_req(pop_req),
		.tx_start(tx_start),
		.tx_char(tx_char),
		.tx_done(tx_done),
		.busy(busy)
	);

	uart_tx #(
		.cycles_per_bit(cycles_per_bit)
	) u_uart_tx (
		.clock(clock),
		.reset(reset),
		.start(tx_start),
		.char_in(tx_char),
		.txd(txd),
		.done(tx_done)
	);

endmodule

/* source/char_sequencer.sv */
`timescale 1ns/1ps

module char_sequencer #(
	parameter int char_gap = 3
) (
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             send_enable,
	input  logic                             have_word,
	input  bt_bridge_pkg::lane_word_t        word,
	output logic                             pop_req,
	output logic                             tx_start,
	output logic [bt_bridge_pkg::byte_w-1:0] tx_char,
	input  logic                             tx_done,
	output logic                             busy
);
	import bt_bridge_pkg::*;

	localparam int gap_w = (char_gap > 1) ? $clog2(char_gap) : 1;

	seq_state_e state;
	seq_state_e state_next;
	lane_word_t held;
	logic [gap_w-1:0] gap_count;
	logic gap_done;
	logic in_gap;
	logic enter_send;

	assign in_gap = (state == seq_gap_id) || (state == seq_gap_sample);
	assign gap_done = (gap_count == gap_w'(char_gap - 1));

	// Pop only if the lane is still there when release comes around
	assign pop_req = (state == seq_release) && have_word;
	assign busy = (state != seq_idle);

	// Identifier first, then the sample
	assign tx_char = (state == seq_send_sample) ? held.sample : held.lane_id;

	always_comb
	begin
		state_next = state;
		case (state)
			seq_idle:
			begin
				// send_enable only matters here, a popped word always finishes
				if (send_enable && have_word)
					state_next = seq_release;
			end
			seq_release:
			begin
				if (have_word)
					state_next = seq_load;
				else
					state_next = seq_idle;
			end
			seq_load:
			begin
				state_next = seq_send_id;
			end
			seq_send_id:
			begin
				if (tx_done)
					state_next = seq_gap_id;
			end
			seq_gap_id:
			begin
				if (gap_done)
					state_next = seq_send_sample;
			end
			seq_send_sample:
			begin
				if (tx_done)
					state_next = seq_gap_sample;
			end
			seq_gap_sample:
			begin
				if (gap_done)
					state_next = seq_idle;
			end
			default:
			begin
				state_next = seq_idle;
			end
		endcase
	end

	// Start pulse in the first cycle of each send state
	assign enter_send = ((state_next == seq_send_id) && (state != seq_send_id)) ||
		((state_next == seq_send_sample) && (state != seq_send_sample));

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= seq_idle;
			tx_start <= 1'b0;
			gap_count <= '0;
		end
		else
		begin
			state <= state_next;
			tx_start <= enter_send;
			// Counts idle line cycles after each character
			if (in_gap && !gap_done)
				gap_count <= gap_count + 1'b1;
			else
				gap_count <= '0;
		end
	end

	// Word is held so the lane head can move on underneath
	always_ff @(posedge clock)
	begin
		if (pop_req)
			held <= word;
	end

endmodule

/* source/sample_intake.sv */
`timescale 1ns/1ps

module sample_intake #(
	parameter int num_lanes = 8
) (
	input  logic                                           clock,
	input  logic                                           reset,
	input  logic [num_lanes-1:0]                           sample_valid,
	input  logic [num_lanes-1:0][bt_bridge_pkg::byte_w-1:0] sample_data,
	input  logic [num_lanes-1:0]                           lane_full,
	output logic [num_lanes-1:0]                           push,
	output bt_bridge_pkg::lane_word_t [num_lanes-1:0]      push_word,
	output logic [num_lanes-1:0]                           overflow
);
	import bt_bridge_pkg::*;

	// A full lane swallows the strobe, the FIFO never sees it
	assign push = sample_valid & ~lane_full;

	// Tag each sample with the index of the lane it came in on
	for (genvar i = 0; i < num_lanes; i++)
	begin : g_frame
		assign push_word[i].lane_id = {{(byte_w - lane_id_w){1'b0}}, lane_id_w'(i)};
		assign push_word[i].sample = sample_data[i];
	end

	// Sticky loss flags, cleared only by reset
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			overflow <= '0;
		else
			overflow <= overflow | (sample_valid & lane_full);
	end

endmodule

/* source/stream_fifo.sv */
`timescale 1ns/1ps

module stream_fifo #(
	parameter int fifo_depth = 4
) (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      push,
	input  bt_bridge_pkg::lane_word_t push_word,
	input  logic                      pop,
	output bt_bridge_pkg::lane_word_t head_word,
	output logic                      empty,
	output logic                      full
);
	import bt_bridge_pkg::*;

	localparam int addr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int count_w = $clog2(fifo_depth + 1);

	lane_word_t mem [fifo_depth];
	logic [addr_w-1:0] rd_ptr;
	logic [addr_w-1:0] wr_ptr;
	logic [count_w-1:0] count;
	logic do_pop;

	assign do_pop = pop && !empty;
	assign empty = (count == '0);
	assign full = (count == count_w'(fifo_depth));

	// Show-ahead, the head is valid whenever empty is low
	assign head_word = mem[rd_ptr];

	always_ff @(posedge clock)
	begin
		if (push)
			mem[wr_ptr] <= push_word;
	end

	// Pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* source/stream_selector.sv */
`timescale 1ns/1ps

module stream_selector #(
	parameter int num_lanes = 8
) (
	input  logic                                      clock,
	input  logic                                      reset,
	input  logic [num_lanes-1:0]                      lane_enable,
	input  logic [num_lanes-1:0]                      lane_empty,
	input  bt_bridge_pkg::lane_word_t [num_lanes-1:0] lane_head,
	input  logic                                      pop_req,
	output logic                                      have_word,
	output bt_bridge_pkg::lane_word_t                 word,
	output logic [num_lanes-1:0]                      lane_pop
);
	import bt_bridge_pkg::*;

	logic [num_lanes-1:0] candidate;
	// First lane to look at in the next search
	logic [lane_id_w-1:0] next_lane;
	logic [lane_id_w-1:0] pick;
	logic serve;

	assign candidate = lane_enable & ~lane_empty;
	assign have_word = |candidate;
	assign serve = pop_req && have_word;

	// Walk backwards so the nearest candidate from next_lane is the last one written
	always_comb
	begin
		int lane;
		pick = next_lane;
		for (int k = num_lanes - 1; k >= 0; k--)
		begin
			lane = (int'(next_lane) + k) % num_lanes;
			if (candidate[lane])
				pick = lane_id_w'(lane);
		end
	end

	assign word = lane_head[pick];

	// Only the chosen lane sees the pop
	always_comb
	begin
		lane_pop = '0;
		if (serve)
			lane_pop[pick] = 1'b1;
	end

	// After a pop the lane just served goes to the back of the line
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			next_lane <= '0;
		else if (serve)
		begin
			if (int'(pick) == num_lanes - 1)
				next_lane <= '0;
			else
				next_lane <= pick + 1'b1;
		end
	end

endmodule

/* source/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
	parameter int cycles_per_bit = 4
) (
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             start,
	input  logic [bt_bridge_pkg::byte_w-1:0] char_in,
	output logic                             txd,
	output logic                             done
);
	import bt_bridge_pkg::*;

	localparam int count_w = (cycles_per_bit > 1) ? $clog2(cycles_per_bit) : 1;
	localparam int index_w = $clog2(byte_w);

	uart_state_e state;
	logic [count_w-1:0] bit_count;
	logic [index_w-1:0] bit_index;
	logic [byte_w-1:0] shift;
	logic bit_end;

	assign bit_end = (bit_count == count_w'(cycles_per_bit - 1));

	// Last cycle of the stop bit
	assign done = (state == uart_stop_bit) && bit_end;

	always_comb
	begin
		case (state)
			uart_start_bit: txd = 1'b0;
			uart_data_bits: txd = shift[0];
			default: txd = 1'b1;
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= uart_idle;
			bit_count <= '0;
			bit_index <= '0;
		end
		else
		begin
			if (state == uart_idle || bit_end)
				bit_count <= '0;
			else
				bit_count <= bit_count + 1'b1;

			case (state)
				uart_idle:
				begin
					// start is dropped while a frame is on the line
					if (start)
						state <= uart_start_bit;
				end
				uart_start_bit:
				begin
					if (bit_end)
					begin
						state <= uart_data_bits;
						bit_index <= '0;
					end
				end
				uart_data_bits:
				begin
					if (bit_end)
					begin
						bit_index <= bit_index + 1'b1;
						if (bit_index == index_w'(byte_w - 1))
							state <= uart_stop_bit;
					end
				end
				uart_stop_bit:
				begin
					if (bit_end)
						state <= uart_idle;
				end
				default:
				begin
					state <= uart_idle;
				end
			endcase
		end
	end

	// LSB first
	always_ff @(posedge clock)
	begin
		if (state == uart_idle && start)
			shift <= char_in;
		else if (state == uart_data_bits && bit_end)
			shift <= shift >> 1;
	end

endmodule

/* test/bt_bridge_asserts.sv */
`timescale 1ns/1ps

module bt_bridge_asserts #(
	parameter int num_lanes = 8
) (
	input logic                 clock,
	input logic                 reset,
	input logic [num_lanes-1:0] lane_pop,
	input logic [num_lanes-1:0] lane_empty,
	input logic                 pop_req,
	input logic                 have_word,
	input logic                 tx_start
);
	int error_count = 0;

	// Selector pops at most one lane, and never an empty one
	pop_onehot: assert property (@(posedge clock) disable iff (reset) $onehot0(lane_pop))
	else
	begin
		$error("lane_pop has more than one lane set");
		error_count++;
	end

	pop_not_empty: assert property (@(posedge clock) disable iff (reset)
		(|lane_pop) |-> ((lane_pop & lane_empty) == '0))
	else
	begin
		$error("lane_pop hit an empty lane");
		error_count++;
	end

	// Sequencer strobes
	start_pulse: assert property (@(posedge clock) disable iff (reset) tx_start |=> !tx_start)
	else
	begin
		$error("tx_start held for more than one cycle");
		error_count++;
	end

	pop_with_word: assert property (@(posedge clock) disable iff (reset) pop_req |-> have_word)
	else
	begin
		$error("pop_req raised without have_word");
		error_count++;
	end

endmodule

// Top-level nets carry both the selector and the sequencer signals
bind bt_bridge_top bt_bridge_asserts #(
	.num_lanes(num_lanes)
) u_asserts (
	.clock(clock),
	.reset(reset),
	.lane_pop(lane_pop),
	.lane_empty(lane_empty),
	.pop_req(pop_req),
	.have_word(have_word),
	.tx_start(tx_start)
);

/* test/bt_bridge_tb.sv */
`timescale 1ns/1ps

module bt_bridge_tb;
	import bt_bridge_pkg::*;

	localparam int num_lanes = 8;
	localparam int fifo_depth = 4;
	localparam int cycles_per_bit = 4;
	localparam int char_gap = 3;
	localparam int period = 4;

	// One stimulus row with the overflow mask expected once it has been applied
	typedef struct packed {
		logic has_sample;
		logic [lane_id_w-1:0] lane;
		logic [byte_w-1:0] sample;
		logic [num_lanes-1:0] lane_enable;
		logic send_enable;
		logic drain;
		logic [7:0] idle_cycles;
		logic [num_lanes-1:0] exp_overflow;
	} row_t;

	logic clock;
	logic reset;
	logic [num_lanes-1:0] sample_valid;
	logic [num_lanes-1:0][byte_w-1:0] sample_data;
	logic [num_lanes-1:0] lane_enable;
	logic send_enable;
	logic txd;
	logic [num_lanes-1:0] overflow;
	logic busy;

	row_t rows[$];
	// Reference model with one queue per lane and the round-robin pointer
	logic [byte_w-1:0] model_q [num_lanes][$];
	int model_next;
	lane_word_t expected[$];
	bit id_pending;
	bit table_ready;

	bt_bridge_top #(
		.num_lanes(num_lanes),
		.fifo_depth(fifo_depth),
		.cycles_per_bit(cycles_per_bit),
		.char_gap(char_gap)
	) DUT (
		.clock(clock),
		.reset(reset),
		.sample_valid(sample_valid),
		.sample_data(sample_data),
		.lane_enable(lane_enable),
		.send_enable(send_enable),
		.txd(txd),
		.overflow(overflow),
		.busy(busy)
	);

	initial
	begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic flag_mismatch(input string name, input logic [31:0] want,
		input logic [31:0] got);
		$display("FAILED %s: expected %h, got %h", name, want, got);
		$display("Test failures found");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic add_row(input logic has_sample, input int lane, input logic [7:0] sample,
		input logic [num_lanes-1:0] en, input logic send, input logic drain,
		input int idle, input logic [num_lanes-1:0] exp_ovf);
		row_t r;
		r.has_sample = has_sample;
		r.lane = lane_id_w'(lane);
		r.sample = sample;
		r.lane_enable = en;
		r.send_enable = send;
		r.drain = drain;
		r.idle_cycles = 8'(idle);
		r.exp_overflow = exp_ovf;
		rows.push_back(r);
	endtask

	task automatic build_table();
		logic [31:0] rng;
		rng = 32'h0b964f49;
		// Single words sent straight away
		add_row(1, 5, 8'ha7, 8'hff, 1, 1, 2, 8'h00);
		add_row(1, 0, 8'h3c, 8'hff, 1, 1, 2, 8'h00);
		// Several lanes queued while halted and then drained
		add_row(1, 6, 8'h61, 8'hff, 0, 0, 1, 8'h00);
		add_row(1, 1, 8'h11, 8'hff, 0, 0, 0, 8'h00);
		add_row(1, 3, 8'h31, 8'hff, 0, 0, 2, 8'h00);
		add_row(1, 1, 8'h12, 8'hff, 0, 0, 1, 8'h00);
		add_row(1, 6, 8'h62, 8'hff, 0, 0, 1, 8'h00);
		add_row(0, 0, 8'h00, 8'hff, 1, 1, 0, 8'h00);
		// Burst over all lanes with pseudo-random bytes
		for (int i = 0; i < 10; i++)
		begin
			rng = xorshift32(rng);
			add_row(1, (i * 5 + 2) % num_lanes, rng[7:0], 8'hff, 0, 0, i % 3, 8'h00);
		end
		add_row(0, 0, 8'h00, 8'hff, 1, 1, 0, 8'h00);
		// Lane 3 masked off so its sample waits
		add_row(1, 3, 8'h3a, 8'hf7, 0, 0, 1, 8'h00);
		add_row(1, 4, 8'h4b, 8'hf7, 0, 0, 1, 8'h00);
		add_row(0, 0, 8'h00, 8'hf7, 1, 1, 0, 8'h00);
		add_row(0, 0, 8'h00, 8'hf7, 1, 0, 60, 8'h00);
		add_row(0, 0, 8'h00, 8'hff, 1, 1, 0, 8'h00);
		// Overfill lane 2 while halted
		for (int i = 0; i < fifo_depth + 2; i++)
			add_row(1, 2, 8'hd0 + 8'(i), 8'hff, 0, 0, 1, (i >= fifo_depth) ? 8'h04 : 8'h00);
		add_row(0, 0, 8'h00, 8'hff, 1, 1, 0, 8'h04);
		add_row(0, 0, 8'h00, 8'hff, 1, 0, 60, 8'h04);
	endtask

	// Round-robin over the enabled lanes starting after the last one served
	task automatic predict_words(input logic [num_lanes-1:0] en);
		int lane;
		bit found;
		lane_word_t w;
		found = 1'b1;
		while (found)
		begin
			found = 1'b0;
			for (int k = 0; k < num_lanes && !found; k++)
			begin
				lane = (model_next + k) % num_lanes;
				if (en[lane] && model_q[lane].size() > 0)
				begin
					w.lane_id = byte_w'(lane);
					w.sample = model_q[lane].pop_front();
					expected.push_back(w);
					model_next = (lane + 1) % num_lanes;
					found = 1'b1;
				end
			end
		end
	endtask

	task automatic quiet_line_check();
		assert (busy == 1'b0) else flag_mismatch("busy", 0, busy);
		assert (txd == 1'b1) else flag_mismatch("txd", 1, txd);
	endtask

	task automatic apply_row(input row_t r);
		sample_valid = '0;
		if (r.has_sample)
		begin
			sample_valid[r.lane] = 1'b1;
			sample_data[r.lane] = r.sample;
			// While halted a lane keeps only fifo_depth entries
			if (r.send_enable || model_q[r.lane].size() < fifo_depth)
				model_q[r.lane].push_back(r.sample);
		end
		lane_enable = r.lane_enable;
		send_enable = r.send_enable;
		if (r.drain)
			predict_words(r.lane_enable);
		next_cycle();
		sample_valid = '0;
		repeat (r.idle_cycles)
		begin
			if (!r.send_enable)
				quiet_line_check();
			next_cycle();
		end
		if (r.drain)
		begin
			while (expected.size() != 0 || id_pending || busy !== 1'b0)
				next_cycle();
		end
		assert (overflow == r.exp_overflow)
		else flag_mismatch("overflow", r.exp_overflow, overflow);
	endtask

	task automatic receive_char(output logic [byte_w-1:0] ch);
		repeat (cycles_per_bit / 2) @(negedge clock);
		assert (txd == 1'b0) else abort_run("Start bit on txd did not stay low");
		// A character on the line means a word is in flight
		assert (busy == 1'b1) else flag_mismatch("busy", 1, busy);
		for (int b = 0; b < byte_w; b++)
		begin
			repeat (cycles_per_bit) @(negedge clock);
			ch[b] = txd;
		end
		repeat (cycles_per_bit) @(negedge clock);
		assert (txd == 1'b1) else abort_run("Stop bit on txd was low");
		// Lands on the first cycle after the frame
		repeat (cycles_per_bit - cycles_per_bit / 2) @(negedge clock);
	endtask

	task automatic score_char(input logic [byte_w-1:0] ch);
		assert (expected.size() > 0) else abort_run("Character on txd with no word expected");
		if (!id_pending)
		begin
			assert (ch == expected[0].lane_id)
			else flag_mismatch("txd lane id", expected[0].lane_id, ch);
			id_pending = 1'b1;
		end
		else
		begin
			assert (ch == expected[0].sample)
			else flag_mismatch("txd sample", expected[0].sample, ch);
			void'(expected.pop_front());
			id_pending = 1'b0;
		end
	endtask

	// Line monitor sampling txd at falling edges where it is stable
	initial
	begin : line_monitor
		logic [byte_w-1:0] ch;
		int high_run;
		bit seen_frame;
		high_run = 0;
		seen_frame = 1'b0;
		@(negedge clock);
		forever
		begin
			if (reset || txd !== 1'b0)
			begin
				if (!reset)
					high_run++;
				@(negedge clock);
			end
			else
			begin
				if (seen_frame)
				begin
					assert (high_run >= char_gap)
					else abort_run("Idle gap on txd shorter than char_gap");
				end
				receive_char(ch);
				score_char(ch);
				seen_frame = 1'b1;
				high_run = 0;
			end
		end
	end

	// Bound checker failures end the run as soon as they are counted
	initial
	begin : assertion_watch
		wait (DUT.u_asserts.error_count != 0);
		$display("Bound assertion on the selector or sequencer failed");
		$display("Test failures found");
		$fatal(1, "Stopped at the first error");
	end

	initial
	begin : watchdog
		int limit;
		wait (table_ready);
		limit = 0;
		foreach (rows[i])
		begin
			limit += 1 + int'(rows[i].idle_cycles);
			if (rows[i].has_sample)
				limit += 2 * 10 * cycles_per_bit + 2 * char_gap + 8;
		end
		limit = 2 * limit + 200;
		repeat (limit) @(posedge clock);
		$display("Test failures found");
		$fatal(1, "Timeout, the run did not finish within %0d cycles", limit);
	end

	initial
	begin : main
		reset = 1'b1;
		sample_valid = '0;
		sample_data = '0;
		lane_enable = '0;
		send_enable = 1'b0;
		model_next = 0;
		id_pending = 1'b0;
		table_ready = 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (2) @(posedge clock);
		#1 reset = 1'b0;
		// Line idle and no flags after reset
		repeat (5)
		begin
			quiet_line_check();
			assert (overflow == '0) else flag_mismatch("overflow", 0, overflow);
			next_cycle();
		end
		foreach (rows[i])
			apply_row(rows[i]);
		assert (expected.size() == 0 && !id_pending) else abort_run("Words still expected at the end");
		$display("All tests passed!");
		$finish;
	end

endmodule
